// File: bench/mem_model.sv
module mem_model (
    input  logic              clk,
    input  logic              mem_rd_i,
    input  logic              mem_wr_i,
    input  dcache_pkg::addr_t mem_addr_i,
    input  dcache_pkg::word_t mem_wdata_i,
    output logic              mem_ok_o,
    output dcache_pkg::word_t mem_rdata_o,
    output int                wr_count_o,
    output int                rd_count_o,
    output int                last_wr_seq_o,
    output int                last_rd_seq_o,
    output dcache_pkg::addr_t last_wr_addr_o,
    output dcache_pkg::word_t last_wr_data_o,
    output dcache_pkg::addr_t last_rd_addr_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    word_t mem [addr_t];
    int    ops;
    int    delay;

    // content before any write depends on every address bit
    function automatic word_t fill_word(addr_t a);
        return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
    endfunction

    initial begin
        mem_ok_o       = 1'b0;
        mem_rdata_o    = '0;
        wr_count_o     = 0;
        rd_count_o     = 0;
        last_wr_seq_o  = 0;
        last_rd_seq_o  = 0;
        last_wr_addr_o = '0;
        last_wr_data_o = '0;
        last_rd_addr_o = '0;
        ops            = 0;
        forever begin
            @(negedge clk);
            if (mem_rd_i || mem_wr_i) begin
                delay = $urandom_range(0, 5);
                repeat (delay) @(negedge clk);
                @(posedge clk);
                #5;
                ops++;
                if (mem_wr_i) begin
                    mem[mem_addr_i] = mem_wdata_i;
                    wr_count_o      = wr_count_o + 1;
                    last_wr_seq_o   = ops;
                    last_wr_addr_o  = mem_addr_i;
                    last_wr_data_o  = mem_wdata_i;
                end else begin
                    mem_rdata_o    = mem.exists(mem_addr_i) ? mem[mem_addr_i] :
                                     fill_word(mem_addr_i);
                    rd_count_o     = rd_count_o + 1;
                    last_rd_seq_o  = ops;
                    last_rd_addr_o = mem_addr_i;
                end
                // ok lasts exactly one cycle
                mem_ok_o = 1'b1;
                @(posedge clk);
                #5;
                mem_ok_o = 1'b0;
            end
        end
    end

endmodule

// File: bench/tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int INDEX_W = 6;
    localparam int AGE_W   = 3;
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS    = 2 ** INDEX_W;
    localparam int N_REQ   = 400;
    localparam int TIMEOUT = 100;

    logic  clk;
    logic  rst;
    logic  rd;
    logic  wr;
    addr_t addr;
    word_t wdata;
    mask_t wmask;
    word_t rdata;
    logic  done;
    logic  mem_rd;
    logic  mem_wr;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_ok;
    word_t mem_rdata;
    int    wr_count;
    int    rd_count;
    int    last_wr_seq;
    int    last_rd_seq;
    addr_t last_wr_addr;
    word_t last_wr_data;
    addr_t last_rd_addr;

    // reference copy of the cache state
    logic [TAG_W-1:0] m_tag [2][SETS];
    logic             m_valid [2][SETS];
    logic             m_dirty [2][SETS];
    logic [AGE_W-1:0] m_age [2][SETS];
    word_t            m_data [2][SETS];
    word_t            ref_mem [addr_t];
    logic [TAG_W-1:0] tag_tab [3];

    logic  exp_hit;
    logic  exp_wb;
    addr_t exp_wb_addr;
    word_t exp_wb_data;
    addr_t exp_rd_addr;
    word_t exp_rdata;
    int    errors;
    int    hits;
    int    wbacks;
    int    accesses;
    logic  hung;

    dcache_top #(
        .INDEX_W (INDEX_W),
        .AGE_W   (AGE_W)
    ) dcache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .rd_i        (rd),
        .wr_i        (wr),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .wmask_i     (wmask),
        .rdata_o     (rdata),
        .done_o      (done),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ok_i    (mem_ok),
        .mem_rdata_i (mem_rdata)
    );

    mem_model mem_inst (
        .clk            (clk),
        .mem_rd_i       (mem_rd),
        .mem_wr_i       (mem_wr),
        .mem_addr_i     (mem_addr),
        .mem_wdata_i    (mem_wdata),
        .mem_ok_o       (mem_ok),
        .mem_rdata_o    (mem_rdata),
        .wr_count_o     (wr_count),
        .rd_count_o     (rd_count),
        .last_wr_seq_o  (last_wr_seq),
        .last_rd_seq_o  (last_rd_seq),
        .last_wr_addr_o (last_wr_addr),
        .last_wr_data_o (last_wr_data),
        .last_rd_addr_o (last_rd_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic word_t mem_word(input addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return mem_inst.fill_word(a);
    endfunction

    // predicts hit, write-back and load data, then updates the copy
    task automatic model_access(input logic is_wr, input addr_t a, input word_t d,
                                input mask_t m);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic               way;
        idx         = a[OFFSET_W +: INDEX_W];
        tag         = a[ADDR_W-1 -: TAG_W];
        exp_wb      = 1'b0;
        exp_rd_addr = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        if (m_valid[0][idx] && (m_tag[0][idx] == tag)) begin
            exp_hit = 1'b1;
            way     = 1'b0;
        end else if (m_valid[1][idx] && (m_tag[1][idx] == tag)) begin
            exp_hit = 1'b1;
            way     = 1'b1;
        end else begin
            exp_hit = 1'b0;
            if (!m_valid[0][idx]) begin
                way = 1'b0;
            end else if (!m_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = (m_age[1][idx] > m_age[0][idx]);
            end
            if (m_valid[way][idx] && m_dirty[way][idx]) begin
                exp_wb               = 1'b1;
                exp_wb_addr          = {m_tag[way][idx], idx, {OFFSET_W{1'b0}}};
                exp_wb_data          = m_data[way][idx];
                ref_mem[exp_wb_addr] = exp_wb_data;
            end
            m_data[way][idx]  = mem_word(exp_rd_addr);
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        exp_rdata = m_data[way][idx];
        if (is_wr) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (m[b]) begin
                    m_data[way][idx][8*b +: 8] = d[8*b +: 8];
                end
            end
            m_dirty[way][idx] = 1'b1;
        end
        m_age[way][idx] = '0;
        if (m_age[~way][idx] != {AGE_W{1'b1}}) begin
            m_age[~way][idx] = m_age[~way][idx] + AGE_W'(1);
        end
    endtask

    // starts 5 ns after a rising edge and returns at the same phase
    task automatic run_access(input int n);
        logic  is_wr;
        addr_t a;
        word_t d;
        mask_t m;
        int    wr0;
        int    rd0;
        int    edges;
        int    gap;
        logic  got;
        is_wr = 1'($urandom_range(0, 1));
        if (n > 0 && $urandom_range(0, 3) != 0) begin
            // long runs on one line drive the other way's age into saturation
            a = {addr[ADDR_W-1:OFFSET_W], OFFSET_W'($urandom_range(0, 7))};
        end else begin
            a = {tag_tab[$urandom_range(0, 2)], INDEX_W'($urandom_range(0, 3)),
                 OFFSET_W'($urandom_range(0, 7))};
        end
        d     = {$urandom, $urandom};
        m     = MASK_W'($urandom);
        wr0   = wr_count;
        rd0   = rd_count;
        model_access(is_wr, a, d, m);
        rd    = !is_wr;
        wr    = is_wr;
        addr  = a;
        wdata = d;
        wmask = m;
        edges = 0;
        got   = 1'b0;
        while (!got && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            got = done;
        end
        if (!got) begin
            $display("timeout: done_o never came for access %0d at %0t", n, $time);
            errors++;
            hung = 1'b1;
        end else begin
            if (exp_hit) begin
                hits++;
                if (edges != 2) begin
                    report_error($sformatf("hit at %h took %0d cycles, expected 2", a, edges));
                end
                if (wr_count != wr0 || rd_count != rd0) begin
                    report_error($sformatf("memory request on a hit at %h", a));
                end
            end else begin
                if (rd_count != rd0 + 1) begin
                    report_error($sformatf("miss at %h made %0d refill reads", a,
                                           rd_count - rd0));
                end else if (last_rd_addr != exp_rd_addr) begin
                    report_error($sformatf("refill read at %h, expected %h", last_rd_addr,
                                           exp_rd_addr));
                end
                if (exp_wb) begin
                    wbacks++;
                    if (wr_count != wr0 + 1) begin
                        report_error($sformatf("dirty miss at %h made %0d writes", a,
                                               wr_count - wr0));
                    end else begin
                        if (last_wr_addr != exp_wb_addr) begin
                            report_error($sformatf("write-back to %h, expected %h",
                                                   last_wr_addr, exp_wb_addr));
                        end
                        if (last_wr_data != exp_wb_data) begin
                            report_error($sformatf("write-back data %h, expected %h",
                                                   last_wr_data, exp_wb_data));
                        end
                        if (last_wr_seq > last_rd_seq) begin
                            report_error($sformatf("refill before write-back at %h", a));
                        end
                    end
                end else if (wr_count != wr0) begin
                    report_error($sformatf("clean miss at %h wrote memory", a));
                end
            end
            if (!is_wr && rdata != exp_rdata) begin
                report_error($sformatf("load %h returned %h, expected %h", a, rdata,
                                       exp_rdata));
            end
            // store merge happens in the done cycle, so hold wr until then
            @(posedge clk);
            #5;
            rd  = 1'b0;
            wr  = 1'b0;
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(posedge clk);
                #5;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h2510));
        errors   = 0;
        hits     = 0;
        wbacks   = 0;
        accesses = 0;
        hung     = 1'b0;
        rst      = 1'b0;
        rd       = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        wdata    = '0;
        wmask    = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
                m_age[w][s]   = '0;
                m_tag[w][s]   = '0;
                m_data[w][s]  = '0;
            end
        end
        // three tags on two ways keep evictions frequent
        for (int i = 0; i < 3; i++) begin
            tag_tab[i] = TAG_W'({$urandom, $urandom});
        end
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b1;
        @(negedge clk);
        if (done || mem_rd || mem_wr) begin
            report_error("done_o, mem_rd_o or mem_wr_o high after reset");
        end
        @(posedge clk);
        #5;
        while (accesses < N_REQ && !hung) begin
            run_access(accesses);
            accesses++;
        end
        $display("accesses %0d, hits %0d, write-backs %0d, errors %0d",
                 accesses, hits, wbacks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: logic/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int INDEX_W = 6
) (
    input  logic                                                      clk,
    input  logic                                                      rst,
    // cpu side
    input  logic                                                      rd_i,
    input  logic                                                      wr_i,
    input  dcache_pkg::addr_t                                         addr_i,
    input  dcache_pkg::word_t                                         wdata_i,
    input  dcache_pkg::mask_t                                         wmask_i,
    output dcache_pkg::word_t                                         rdata_o,
    output logic                                                      done_o,
    // lookup results
    input  logic                                                      hit_i,
    input  logic                                                      hit_way_i,
    input  logic                                                      vict_way_i,
    input  logic                                                      vict_dirty_i,
    input  logic                                                      vict_valid_i,
    input  logic [dcache_pkg::ADDR_W-INDEX_W-dcache_pkg::OFFSET_W-1:0] vict_tag_i,
    input  dcache_pkg::word_t                                         rdata0_i,
    input  dcache_pkg::word_t                                         rdata1_i,
    // array writes
    output logic                                                      tag_we_o,
    output logic                                                      dirty_we_o,
    output logic                                                      tag_way_o,
    output logic                                                      dirty_o,
    output logic                                                      data_we_o,
    output logic                                                      data_way_o,
    output dcache_pkg::word_t                                         data_wdata_o,
    output dcache_pkg::mask_t                                         data_wmask_o,
    output logic                                                      touch_o,
    output logic                                                      touch_way_o,
    // memory side
    output logic                                                      mem_rd_o,
    output logic                                                      mem_wr_o,
    output dcache_pkg::addr_t                                         mem_addr_o,
    output dcache_pkg::word_t                                         mem_wdata_o,
    input  logic                                                      mem_ok_i,
    input  dcache_pkg::word_t                                         mem_rdata_i
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        way_q;
    word_t       rdata_q;
    word_t       vict_data;
    logic        refill_ok;
    logic        store_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (rd_i || wr_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = DONE;
                end else if (vict_valid_i && vict_dirty_i) begin
                    state_d = WBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            // wait here as long as memory is busy
            WBACK: begin
                if (mem_ok_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ok_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            way_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // hit way or the chosen victim becomes the way of this access
            if (state_q == LOOKUP) begin
                way_q <= hit_i ? hit_way_i : vict_way_i;
            end
        end
    end

    // load result comes from the hit way or straight off the refill
    always_ff @(posedge clk) begin
        if ((state_q == LOOKUP) && hit_i) begin
            rdata_q <= hit_way_i ? rdata1_i : rdata0_i;
        end else if (refill_ok) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign refill_ok  = (state_q == REFILL) && mem_ok_i;
    assign store_done = (state_q == DONE) && wr_i;
    assign vict_data  = way_q ? rdata1_i : rdata0_i;

    // refill writes the whole word, stores merge their bytes in DONE
    assign tag_we_o     = refill_ok;
    assign dirty_o      = wr_i;
    assign dirty_we_o   = store_done;
    assign tag_way_o    = way_q;
    assign data_we_o    = refill_ok || store_done;
    assign data_way_o   = way_q;
    assign data_wdata_o = refill_ok ? mem_rdata_i : wdata_i;
    assign data_wmask_o = refill_ok ? {MASK_W{1'b1}} : wmask_i;

    assign touch_o     = (state_q == DONE);
    assign touch_way_o = way_q;

    assign mem_wr_o    = (state_q == WBACK);
    assign mem_rd_o    = (state_q == REFILL);
    assign mem_wdata_o = vict_data;

    // write-back goes to the victim's own line
    assign mem_addr_o = (state_q == WBACK) ?
                        {vict_tag_i, addr_i[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}} :
                        {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign done_o  = (state_q == DONE);
    assign rdata_o = rdata_q;

endmodule

// File: logic/dcache_data_store.sv
module dcache_data_store #(
    parameter int INDEX_W = 6
) (
    input  logic              clk,
    input  dcache_pkg::addr_t addr_i,
    input  logic              we_i,
    input  logic              way_i,
    input  dcache_pkg::word_t wdata_i,
    input  dcache_pkg::mask_t wmask_i,
    output dcache_pkg::word_t rdata0_o,
    output dcache_pkg::word_t rdata1_o
);
    import dcache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    word_t              data_q [2][SETS];
    logic [INDEX_W-1:0] idx;

    assign idx = addr_i[OFFSET_W +: INDEX_W];

    // only enabled bytes change
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (wmask_i[b]) begin
                    data_q[way_i][idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // both ways read every cycle
    assign rdata0_o = data_q[0][idx];
    assign rdata1_o = data_q[1][idx];

endmodule

// File: logic/dcache_pkg.sv
package dcache_pkg;

    // byte address and data word
    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int MASK_W   = DATA_W / 8;
    localparam int OFFSET_W = 3;

    typedef logic [DATA_W-1:0] word_t;

    // bit n enables byte n of the word
    typedef logic [MASK_W-1:0] mask_t;

    typedef logic [ADDR_W-1:0] addr_t;

    // one FSM serves both loads and stores
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WBACK,
        REFILL,
        DONE
    } ctrl_state_e;

endpackage

// File: logic/dcache_replace.sv
module dcache_replace #(
    parameter int INDEX_W = 6,
    parameter int AGE_W   = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  dcache_pkg::addr_t addr_i,
    input  logic              touch_i,
    input  logic              touch_way_i,
    input  logic              valid0_i,
    input  logic              valid1_i,
    output logic              vict_way_o
);
    import dcache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    logic [1:0][SETS-1:0][AGE_W-1:0] age_q;
    logic [INDEX_W-1:0]              idx;
    logic                            other;

    assign idx   = addr_i[OFFSET_W +: INDEX_W];
    assign other = ~touch_way_i;

    // touched way gets young, the other one ages up to saturation
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            age_q <= '0;
        end else if (touch_i) begin
            age_q[touch_way_i][idx] <= '0;
            if (age_q[other][idx] != {AGE_W{1'b1}}) begin
                age_q[other][idx] <= age_q[other][idx] + 1'b1;
            end
        end
    end

    // free way first, else the older one, way 0 on a tie
    always_comb begin
        if (!valid0_i) begin
            vict_way_o = 1'b0;
        end else if (!valid1_i) begin
            vict_way_o = 1'b1;
        end else begin
            vict_way_o = (age_q[1][idx] > age_q[0][idx]);
        end
    end

endmodule

// File: logic/dcache_tag_store.sv
module dcache_tag_store #(
    parameter int INDEX_W = 6
) (
    input  logic                                                      clk,
    input  logic                                                      rst,
    input  dcache_pkg::addr_t                                         addr_i,
    input  logic                                                      tag_we_i,
    input  logic                                                      dirty_we_i,
    input  logic                                                      way_i,
    input  logic                                                      dirty_i,
    output logic                                                      hit_o,
    output logic                                                      hit_way_o,
    output logic                                                      valid0_o,
    output logic                                                      valid1_o,
    input  logic                                                      vict_way_i,
    output logic                                                      vict_valid_o,
    output logic                                                      vict_dirty_o,
    output logic [dcache_pkg::ADDR_W-INDEX_W-dcache_pkg::OFFSET_W-1:0] vict_tag_o
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS  = 2 ** INDEX_W;

    logic [TAG_W-1:0]           tag_q [2][SETS];
    logic [1:0][SETS-1:0]       valid_q;
    logic [1:0][SETS-1:0]       dirty_q;
    logic [INDEX_W-1:0]         idx;
    logic [TAG_W-1:0]           tag;
    logic                       hit0;
    logic                       hit1;

    assign idx = addr_i[OFFSET_W +: INDEX_W];
    assign tag = addr_i[ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_q[way_i][idx] <= tag;
        end
    end

    // a fill installs the line, a store hit only marks it dirty
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (tag_we_i) begin
            valid_q[way_i][idx] <= 1'b1;
            dirty_q[way_i][idx] <= dirty_i;
        end else if (dirty_we_i) begin
            dirty_q[way_i][idx] <= 1'b1;
        end
    end

    assign hit0      = valid_q[0][idx] && (tag_q[0][idx] == tag);
    assign hit1      = valid_q[1][idx] && (tag_q[1][idx] == tag);
    assign hit_o     = hit0 || hit1;
    assign hit_way_o = hit1;

    assign valid0_o = valid_q[0][idx];
    assign valid1_o = valid_q[1][idx];

    assign vict_valid_o = valid_q[vict_way_i][idx];
    assign vict_dirty_o = dirty_q[vict_way_i][idx];
    assign vict_tag_o   = tag_q[vict_way_i][idx];

endmodule

// File: logic/dcache_top.sv
module dcache_top #(
    parameter int INDEX_W = 6,
    parameter int AGE_W   = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_i,
    input  logic              wr_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::word_t wdata_i,
    input  dcache_pkg::mask_t wmask_i,
    output dcache_pkg::word_t rdata_o,
    output logic              done_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::word_t mem_wdata_o,
    input  logic              mem_ok_i,
    input  dcache_pkg::word_t mem_rdata_i
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    logic             hit;
    logic             hit_way;
    logic             valid0;
    logic             valid1;
    logic             vict_way;
    logic             vict_valid;
    logic             vict_dirty;
    logic [TAG_W-1:0] vict_tag;
    word_t            rdata0;
    word_t            rdata1;
    logic             tag_we;
    logic             dirty_we;
    logic             tag_way;
    logic             dirty;
    logic             data_we;
    logic             data_way;
    word_t            data_wdata;
    mask_t            data_wmask;
    logic             touch;
    logic             touch_way;

    dcache_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .rd_i         (rd_i),
        .wr_i         (wr_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .wmask_i      (wmask_i),
        .rdata_o      (rdata_o),
        .done_o       (done_o),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .vict_way_i   (vict_way),
        .vict_dirty_i (vict_dirty),
        .vict_valid_i (vict_valid),
        .vict_tag_i   (vict_tag),
        .rdata0_i     (rdata0),
        .rdata1_i     (rdata1),
        .tag_we_o     (tag_we),
        .dirty_we_o   (dirty_we),
        .tag_way_o    (tag_way),
        .dirty_o      (dirty),
        .data_we_o    (data_we),
        .data_way_o   (data_way),
        .data_wdata_o (data_wdata),
        .data_wmask_o (data_wmask),
        .touch_o      (touch),
        .touch_way_o  (touch_way),
        .mem_rd_o     (mem_rd_o),
        .mem_wr_o     (mem_wr_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ok_i     (mem_ok_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    dcache_tag_store #(
        .INDEX_W (INDEX_W)
    ) u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .addr_i       (addr_i),
        .tag_we_i     (tag_we),
        .dirty_we_i   (dirty_we),
        .way_i        (tag_way),
        .dirty_i      (dirty),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .valid0_o     (valid0),
        .valid1_o     (valid1),
        .vict_way_i   (vict_way),
        .vict_valid_o (vict_valid),
        .vict_dirty_o (vict_dirty),
        .vict_tag_o   (vict_tag)
    );

    dcache_data_store #(
        .INDEX_W (INDEX_W)
    ) u_data_store (
        .clk      (clk),
        .addr_i   (addr_i),
        .we_i     (data_we),
        .way_i    (data_way),
        .wdata_i  (data_wdata),
        .wmask_i  (data_wmask),
        .rdata0_o (rdata0),
        .rdata1_o (rdata1)
    );

    dcache_replace #(
        .INDEX_W (INDEX_W),
        .AGE_W   (AGE_W)
    ) u_replace (
        .clk         (clk),
        .rst         (rst),
        .addr_i      (addr_i),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .valid0_i    (valid0),
        .valid1_i    (valid1),
        .vict_way_o  (vict_way)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_dcache -f sim.f -o sim_dcache || exit 1
out="$(./obj_dir/sim_dcache)"
echo "$out"
echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1

// File: sim.f
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_replace.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
bench/mem_model.sv
bench/tb_dcache.sv
